/* verilog/tcdm_pkg.sv */
/*
  Shared types for the two-bank TCDM scratchpad.
  Port words are 32 bits wide with four byte lanes. Banks are word interleaved.
*/
package tcdm_pkg;

  localparam int unsigned NUM_BANKS = 2; // Interleaving is fixed to two banks

  typedef logic [31:0] addr_t;      // Byte address on the port
  typedef logic [31:0] data_t;      // Data word
  typedef logic [3:0]  be_t;        // One enable per byte lane
  typedef logic [31:0] word_idx_t;  // Word index inside one bank
  typedef logic [31:0] delay_cnt_t; // Grant wait counter
  typedef logic [$clog2(NUM_BANKS)-1:0] bank_sel_t;

  typedef struct packed {
    logic  req;
    logic  we;   // 1 = write, 0 = read
    be_t   be;
    addr_t addr;
    data_t data;
  } tcdm_req_t;

  typedef struct packed {
    logic  gnt;
    logic  valid;
    logic  err;  // Access outside the memory
    data_t data;
  } tcdm_rsp_t;

  typedef struct packed {
    logic      req;
    logic      we;
    be_t       be;
    word_idx_t idx;
    data_t     data;
  } bank_req_t;

  typedef struct packed {
    logic  gnt;
    logic  valid;
    data_t data;
  } bank_rsp_t;

  // Bank picked by the low word bit of a byte offset
  function automatic bank_sel_t bank_sel(addr_t off);
    return bank_sel_t'((off >> 2) % NUM_BANKS);
  endfunction

  // Word index inside the picked bank
  function automatic word_idx_t bank_idx(addr_t off);
    return word_idx_t'((off >> 2) / NUM_BANKS);
  endfunction

endpackage

/* verilog/tcdm_bank.sv */
/*
  One scratchpad bank. A held request is granted after DELAY_CYCLES waits.
  Storage content is undefined after power-up. idx must be below BANK_WORDS
  whenever req is high.
*/
module tcdm_bank import tcdm_pkg::*; #(
  parameter int unsigned BANK_WORDS   = 32, // Words held by this bank
  parameter int unsigned DELAY_CYCLES = 0   // Wait cycles before a grant
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  bank_req_t req_i,
  output bank_rsp_t rsp_o
);

  localparam int unsigned LANES      = $bits(be_t);     // Bytes per word
  localparam int unsigned BANK_BYTES = BANK_WORDS * LANES;

  logic [7:0] mem_q [BANK_BYTES]; // Byte storage

  delay_cnt_t delay_q;   // Remaining wait cycles of the held request
  logic       gnt;
  word_idx_t  byte_base; // First byte of the addressed word
  data_t      rd_data;   // Whole word at idx
  logic       valid_q;
  data_t      data_q;

  // idx is already word aligned, so lane 0 sits at idx*4
  assign byte_base = req_i.idx << 2;

  // Grant once the wait has run out
  assign gnt = req_i.req && (delay_q == '0);

  // Grant delay counter
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      delay_q <= delay_cnt_t'(DELAY_CYCLES);
    end else if (!req_i.req || gnt) begin
      delay_q <= delay_cnt_t'(DELAY_CYCLES); // Reload for the next request
    end else begin
      delay_q <= delay_q - 1'b1;             // Request held, keep waiting
    end
  end

  // Byte-enable write on a granted write
  always_ff @(posedge clk_i) begin
    if (gnt && req_i.we) begin
      for (int b = 0; b < LANES; b++) begin
        if (req_i.be[b]) begin
          mem_q[byte_base + b] <= req_i.data[8*b +: 8];
        end
      end
    end
  end

  // Assemble the addressed word from its lanes
  always_comb begin
    for (int b = 0; b < LANES; b++) begin
      rd_data[8*b +: 8] = mem_q[byte_base + b]; // Lane b of the word
    end
  end

  // Response register, one cycle after the grant edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      data_q  <= '0;
    end else if (gnt) begin
      valid_q <= 1'b1;
      // Writes loop the write data back, reads return the stored word
      data_q  <= req_i.we ? req_i.data : rd_data;
    end else begin
      valid_q <= 1'b0;
      data_q  <= '0; // Data stays zero between responses
    end
  end

  assign rsp_o.gnt   = gnt;     // Combinational from req
  assign rsp_o.valid = valid_q; // Single-cycle pulse
  assign rsp_o.data  = data_q;

endmodule

/* verilog/tcdm_bank_router.sv */
/*
  Address decode and response merge for two word-interleaved banks.
  BASE_ADDR must be word aligned and BASE_ADDR + MEM_WORDS*4 must not wrap.
  Out-of-range accesses are granted at once and answered with err.
*/
module tcdm_bank_router import tcdm_pkg::*; #(
  parameter addr_t       BASE_ADDR = 32'h0, // First byte of the memory
  parameter int unsigned MEM_WORDS = 64     // Words over all banks, even
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  tcdm_req_t req_i,
  output tcdm_rsp_t rsp_o,
  output bank_req_t bank_req_o [NUM_BANKS],
  input  bank_rsp_t bank_rsp_i [NUM_BANKS]
);

  localparam addr_t MEM_BYTES = addr_t'(MEM_WORDS * 4); // Size of the window

  addr_t     offset;   // Aligned byte offset from BASE_ADDR
  logic      in_range;
  bank_sel_t sel;      // Target bank
  word_idx_t idx;      // Word inside the target bank
  logic      err_q;    // Pending error response

  // Addresses below the base wrap to large offsets and fail the range check
  assign offset   = (req_i.addr - BASE_ADDR) & ~addr_t'(3);
  assign in_range = offset < MEM_BYTES;
  assign sel      = bank_sel(offset); // Address bit 2
  assign idx      = bank_idx(offset); // Upper word bits

  // Same payload to every bank, req only to the selected one
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      bank_req_o[b].req  = req_i.req && in_range && (sel == bank_sel_t'(b));
      bank_req_o[b].we   = req_i.we;
      bank_req_o[b].be   = req_i.be;
      bank_req_o[b].idx  = idx;
      bank_req_o[b].data = req_i.data;
    end
  end

  // Out-of-range request is granted in the same cycle
  // The flag produces the err pulse after the grant edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req_i.req && !in_range;
    end
  end

  // Response merge
  always_comb begin
    // Grant from the addressed bank, or at once for a bad address
    rsp_o.gnt   = in_range ? bank_rsp_i[sel].gnt : req_i.req;
    rsp_o.valid = err_q;
    rsp_o.err   = err_q;
    rsp_o.data  = '0;    // Error answers carry zero
    // At most one bank answers in any cycle
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (bank_rsp_i[b].valid) begin
        rsp_o.valid = 1'b1;
        rsp_o.data  = bank_rsp_i[b].data;
      end
    end
  end

endmodule

/* verilog/tcdm_mem_top.sv */
/*
  Two-bank TCDM scratchpad with one req/gnt/valid port.
  One transaction in flight at a time. MEM_WORDS must be even.
*/
module tcdm_mem_top import tcdm_pkg::*; #(
  parameter addr_t       BASE_ADDR    = 32'h1000, // First byte of the memory
  parameter int unsigned MEM_WORDS    = 64,       // Total words, even
  parameter int unsigned DELAY_CYCLES = 2         // Wait cycles before a grant
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  tcdm_req_t req_i,
  output tcdm_rsp_t rsp_o
);

  localparam int unsigned BANK_WORDS = MEM_WORDS / NUM_BANKS; // Words per bank

  bank_req_t bank_req [NUM_BANKS]; // Router to banks
  bank_rsp_t bank_rsp [NUM_BANKS]; // Banks to router

  tcdm_bank_router #(
    .BASE_ADDR (BASE_ADDR),
    .MEM_WORDS (MEM_WORDS)
  ) i_router (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .rsp_o      (rsp_o),
    .bank_req_o (bank_req),
    .bank_rsp_i (bank_rsp)
  );

  // Even words
  tcdm_bank #(
    .BANK_WORDS   (BANK_WORDS),
    .DELAY_CYCLES (DELAY_CYCLES)
  ) i_bank0 (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (bank_req[0]),
    .rsp_o  (bank_rsp[0])
  );

  // Odd words
  tcdm_bank #(
    .BANK_WORDS   (BANK_WORDS),
    .DELAY_CYCLES (DELAY_CYCLES)
  ) i_bank1 (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (bank_req[1]),
    .rsp_o  (bank_rsp[1])
  );

endmodule

/* sim/tb_clk_gen.sv */
/*
  Testbench clock and reset source.
  Reset is low from time zero and released on a falling edge.
*/
module tb_clk_gen #(
  parameter int unsigned PERIOD_NS  = 10, // Clock period
  parameter int unsigned RST_CYCLES = 4   // Rising edges seen in reset
) (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1; // Release away from the active edge
  end

endmodule

/* sim/tb_tcdm_mem.sv */
/*
  Table-driven testbench for the two-bank TCDM scratchpad.
  Reads only touch words written earlier, since bank storage starts undefined.
  One request is in flight at a time.
*/
module tb_tcdm_mem import tcdm_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam addr_t       BASE_ADDR    = 32'h1000;
  localparam int unsigned MEM_WORDS    = 64;
  localparam int unsigned DELAY_CYCLES = 2;
  localparam int unsigned CLK_PERIOD   = 10; // ns
  localparam int unsigned GNT_LIMIT    = DELAY_CYCLES + 8; // Give up on a grant after this

  // One row of the stimulus table
  typedef struct packed {
    logic  we;
    be_t   be;
    addr_t addr;
    data_t data;
    logic  exp_err;
    data_t exp_data;
  } entry_t;

  logic      clk;
  logic      rst_n;
  tcdm_req_t req;
  tcdm_rsp_t rsp;

  entry_t     table_q[$];
  logic [7:0] ref_mem [MEM_WORDS*4]; // Byte image of the whole memory
  data_t      lcg_state = 32'd51;    // Seed
  logic       table_done = 1'b0;
  logic       entry_ok;
  int         pass_cnt = 0;
  int         fail_cnt = 0;

  tb_clk_gen #(
    .PERIOD_NS  (CLK_PERIOD),
    .RST_CYCLES (4)
  ) i_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  tcdm_mem_top #(
    .BASE_ADDR    (BASE_ADDR),
    .MEM_WORDS    (MEM_WORDS),
    .DELAY_CYCLES (DELAY_CYCLES)
  ) i_dut (
    .clk_i  (clk),
    .rst_ni (rst_n),
    .req_i  (req),
    .rsp_o  (rsp)
  );

  // Linear congruential generator for write data
  function automatic data_t next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Appends one access and predicts its answer from the byte model
  function automatic void add_entry(input logic we, input be_t be, input addr_t addr);
    entry_t e;
    addr_t  off;
    off        = addr - BASE_ADDR;
    off[1:0]   = 2'b00;              // Containing word
    e.we       = we;
    e.be       = be;
    e.addr     = addr;
    e.data     = we ? next_rand() : '0;
    e.exp_err  = 1'b0;
    e.exp_data = '0;
    if (off >= MEM_WORDS * 4) begin
      e.exp_err = 1'b1;              // Outside the window, memory untouched
    end else if (we) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) ref_mem[off + b] = e.data[8*b +: 8];
      end
      e.exp_data = e.data;           // Write data comes back unchanged
    end else begin
      for (int b = 0; b < 4; b++) begin
        e.exp_data[8*b +: 8] = ref_mem[off + b];
      end
    end
    table_q.push_back(e);
  endfunction

  function automatic void build_table();
    // Full words in bank 0 and bank 1, first and last pair
    add_entry(1'b1, 4'hF, 32'h1000);
    add_entry(1'b1, 4'hF, 32'h1004);
    add_entry(1'b1, 4'hF, 32'h10F8);
    add_entry(1'b1, 4'hF, 32'h10FC);
    add_entry(1'b0, 4'hF, 32'h1000);
    add_entry(1'b0, 4'hF, 32'h1004);
    add_entry(1'b0, 4'hF, 32'h10F8);
    add_entry(1'b0, 4'hF, 32'h10FC);
    // Partial writes merge into the stored words
    add_entry(1'b1, 4'b0101, 32'h1000);
    add_entry(1'b1, 4'b1010, 32'h1004);
    add_entry(1'b1, 4'b0001, 32'h10F8);
    add_entry(1'b1, 4'b0110, 32'h10FC);
    add_entry(1'b0, 4'hF, 32'h1000);
    add_entry(1'b0, 4'hF, 32'h1004);
    add_entry(1'b0, 4'hF, 32'h10F8);
    add_entry(1'b0, 4'hF, 32'h10FC);
    // Misaligned addresses hit the containing word
    add_entry(1'b1, 4'hF, 32'h1013);
    add_entry(1'b0, 4'hF, 32'h1011);
    add_entry(1'b1, 4'hF, 32'h1014);
    add_entry(1'b1, 4'b1001, 32'h1016);
    add_entry(1'b0, 4'hF, 32'h1017);
    add_entry(1'b0, 4'hF, 32'h1012);
    // Below the base, at the end of the window, far away
    add_entry(1'b1, 4'hF, 32'h0FFC);
    add_entry(1'b0, 4'hF, 32'h0FFC);
    add_entry(1'b1, 4'hF, 32'h1100);
    add_entry(1'b0, 4'hF, 32'h1103);
    add_entry(1'b1, 4'hF, 32'h0000);
    // Memory must be unchanged by the rejected writes
    add_entry(1'b0, 4'hF, 32'h1000);
    add_entry(1'b0, 4'hF, 32'h1004);
    add_entry(1'b0, 4'hF, 32'h10FC);
  endfunction

  task automatic report_mismatch(input string sig, input data_t got, input data_t exp);
    $display("ERROR t=%0t %s got %0h expected %0h", $time, sig, got, exp);
    entry_ok = 1'b0;
  endtask

  task automatic report_problem(input string msg);
    $display("Failure at t=%0t: %s", $time, msg);
    entry_ok = 1'b0;
  endtask

  // Drives one table row and checks grant timing and the response
  task automatic apply_entry(input int n);
    entry_t      e;
    int unsigned waits;
    int unsigned exp_waits;
    e         = table_q[n];
    exp_waits = e.exp_err ? 1 : DELAY_CYCLES + 1;
    entry_ok  = 1'b1;
    @(negedge clk);
    req.req  = 1'b1;
    req.we   = e.we;
    req.be   = e.be;
    req.addr = e.addr;
    req.data = e.data;
    #1; // Combinational gnt settles
    waits = 1;
    assert (!rsp.valid) else report_problem("valid raised before the grant edge");
    while (!rsp.gnt && waits < GNT_LIMIT) begin
      @(negedge clk);  // Held request, sample mid cycle
      waits++;
      assert (!rsp.valid) else report_problem("valid raised before the grant edge");
    end
    assert (rsp.gnt) else report_problem("request never granted");
    assert (waits == exp_waits) else report_mismatch("rsp_o.gnt cycle", waits, exp_waits);
    @(negedge clk);    // Grant edge has passed
    assert (rsp.valid === 1'b1) else report_mismatch("rsp_o.valid", rsp.valid, 1'b1);
    assert (rsp.err === e.exp_err) else report_mismatch("rsp_o.err", rsp.err, e.exp_err);
    assert (rsp.data === e.exp_data) else report_mismatch("rsp_o.data", rsp.data, e.exp_data);
    req = '0;
    @(negedge clk);
    assert (rsp.valid === 1'b0) else report_problem("valid held longer than one cycle");
    if (entry_ok) pass_cnt++;
    else fail_cnt++;
    $display("entry %2d %s addr=%h be=%b : %s", n, e.we ? "write" : "read ", e.addr, e.be,
             entry_ok ? "ok" : "mismatch");
  endtask

  initial begin
    req = '0; // Idle port during reset
    build_table();
    table_done = 1'b1;
    @(posedge rst_n);
    for (int i = 0; i < table_q.size(); i++) begin
      apply_entry(i);
    end
    $display("Summary: %0d entries passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    int unsigned limit;
    wait (table_done);
    limit = table_q.size() * (DELAY_CYCLES + 4) + 20; // Clock periods
    #(limit * CLK_PERIOD);
    $display("Watchdog: run did not finish within %0d clock periods", limit);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* files.f */
verilog/tcdm_pkg.sv
verilog/tcdm_bank.sv
verilog/tcdm_bank_router.sv
verilog/tcdm_mem_top.sv
sim/tb_clk_gen.sv
sim/tb_tcdm_mem.sv
